// File: rtl/slide_pkg.sv
/*
 * Sizes assume 64-bit elements only and power-of-two lane and word counts,
 * so a register address is the register number concatenated with the word index
 */
package slide_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // One 64-bit element per lane per register word
  localparam int unsigned NrLanes          = 4;
  localparam int unsigned ElemWidth        = 64;
  localparam int unsigned StrbWidth        = ElemWidth / 8;
  localparam int unsigned VlenElems        = 32;
  localparam int unsigned WordsPerReg      = VlenElems / NrLanes;
  // Instruction id space, one done bit per id
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned InsnQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  //////////////////////////////////////////////////
  // Derived widths
  //////////////////////////////////////////////////

  localparam int unsigned LaneIdxWidth   = $clog2(NrLanes);
  localparam int unsigned WordIdxWidth   = $clog2(WordsPerReg);
  localparam int unsigned InsnPntWidth   = $clog2(InsnQueueDepth);
  localparam int unsigned ResultPntWidth = $clog2(ResultQueueDepth);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  typedef logic [ElemWidth-1:0]          elem_t;
  typedef logic [StrbWidth-1:0]          strb_t;
  typedef logic [$clog2(NrVInsn)-1:0]    vid_t;
  // Holds 0 up to VlenElems inclusive
  typedef logic [$clog2(VlenElems):0]    vl_t;
  typedef logic [4:0]                    vreg_t;
  typedef logic [$bits(vreg_t)+WordIdxWidth-1:0] vaddr_t;
  // Element pointer inside a word, 0 up to NrLanes inclusive
  typedef logic [LaneIdxWidth:0]         elem_pnt_t;

endpackage

// File: rtl/slide_insn_queue.sv
/*
 * Circular store of in-flight slides, one entry per uncommitted instruction
 * An entry leaves issue on the engine's last word and commit on the last drain
 */
module slide_insn_queue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Request side
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  slide_pkg::slide_op_e         req_op_i,
  input  slide_pkg::vid_t              req_id_i,
  input  slide_pkg::vl_t               req_vl_i,
  input  slide_pkg::vl_t               req_stride_i,
  input  slide_pkg::vreg_t             req_vd_i,
  // Issue entry towards the engine
  output logic                         issue_valid_o,
  output slide_pkg::slide_op_e         issue_op_o,
  output slide_pkg::vid_t              issue_id_o,
  output slide_pkg::vl_t               issue_vl_o,
  output slide_pkg::vl_t               issue_stride_o,
  output slide_pkg::vreg_t             issue_vd_o,
  input  logic                         issue_done_i,
  // Commit side
  input  logic                         drain_last_i,
  output logic [slide_pkg::NrVInsn-1:0] done_o
);
  import slide_pkg::*;

  // Instruction store
  slide_op_e op_q     [InsnQueueDepth];
  vid_t      id_q     [InsnQueueDepth];
  vl_t       vl_q     [InsnQueueDepth];
  vl_t       stride_q [InsnQueueDepth];
  vreg_t     vd_q     [InsnQueueDepth];

  // Pointers for the three phases and the counts of pending entries
  logic [InsnPntWidth-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [InsnPntWidth:0]   issue_cnt_q, commit_cnt_q;
  logic                    accept;

  // Room while fewer than InsnQueueDepth are uncommitted
  assign req_ready_o = (commit_cnt_q < InsnQueueDepth);
  assign accept      = req_valid_i && req_ready_o;

  // Issue entry is the oldest one not yet run by the engine
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign issue_op_o     = op_q[issue_pnt_q];
  assign issue_id_o     = id_q[issue_pnt_q];
  assign issue_vl_o     = vl_q[issue_pnt_q];
  assign issue_stride_o = stride_q[issue_pnt_q];
  assign issue_vd_o     = vd_q[issue_pnt_q];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]     <= req_op_i;
      id_q[accept_pnt_q]     <= req_id_i;
      vl_q[accept_pnt_q]     <= req_vl_i;
      stride_q[accept_pnt_q] <= req_stride_i;
      vd_q[accept_pnt_q]     <= req_vd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == InsnQueueDepth - 1) ? '0 : accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= (issue_pnt_q == InsnQueueDepth - 1) ? '0 : issue_pnt_q + 1'b1;
      end
      if (drain_last_i) begin
        commit_pnt_q <= (commit_pnt_q == InsnQueueDepth - 1) ? '0 : commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + accept - issue_done_i;
      commit_cnt_q <= commit_cnt_q + accept - drain_last_i;
      // One-cycle done pulse for the id whose last word just retired
      done_o <= drain_last_i ? (NrVInsn'(1) << id_q[commit_pnt_q]) : '0;
    end
  end

endmodule

// File: rtl/slide_engine.sv
/*
 * Moves elements from the operand stream into destination words, 64-bit elements only
 * Slide-down operands must start at source word stride / NrLanes
 */
module slide_engine (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Issue entry
  input  logic                                           issue_valid_i,
  input  slide_pkg::slide_op_e                           issue_op_i,
  input  slide_pkg::vid_t                                issue_id_i,
  input  slide_pkg::vl_t                                 issue_vl_i,
  input  slide_pkg::vl_t                                 issue_stride_i,
  input  slide_pkg::vreg_t                               issue_vd_i,
  output logic                                           issue_done_o,
  // Operand stream, one word across all lanes
  input  slide_pkg::elem_t [slide_pkg::NrLanes-1:0]      operand_i,
  input  logic [slide_pkg::NrLanes-1:0]                  operand_valid_i,
  output logic [slide_pkg::NrLanes-1:0]                  operand_ready_o,
  // Result word towards the staging queue
  input  logic                                           full_i,
  output logic                                           push_o,
  output slide_pkg::vid_t                                push_id_o,
  output slide_pkg::vaddr_t                              push_addr_o,
  output slide_pkg::elem_t [slide_pkg::NrLanes-1:0]      push_wdata_o,
  output slide_pkg::strb_t [slide_pkg::NrLanes-1:0]      push_be_o,
  output logic                                           push_last_o
);
  import slide_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e                  state_d, state_q;
  // Element pointers inside the current input and output words
  elem_pnt_t               in_pnt_d, in_pnt_q;
  elem_pnt_t               out_pnt_d, out_pnt_q;
  // Destination word index and elements still to move
  logic [WordIdxWidth-1:0] word_d, word_q;
  vl_t                     rem_d, rem_q;
  // Partially built destination word
  elem_t [NrLanes-1:0]     acc_wdata_q;
  strb_t [NrLanes-1:0]     acc_be_d, acc_be_q;

  elem_pnt_t in_room, out_room, move_cnt;
  logic      fire, last;

  assign in_room  = elem_pnt_t'(NrLanes) - in_pnt_q;
  assign out_room = elem_pnt_t'(NrLanes) - out_pnt_q;

  // Elements moved this cycle, capped by both words and the remaining count
  always_comb begin
    move_cnt = (in_room < out_room) ? in_room : out_room;
    if (rem_q < vl_t'(move_cnt)) begin
      move_cnt = elem_pnt_t'(rem_q);
    end
  end

  // A whole operand word and room downstream are needed
  assign fire = (state_q == RUN) && (&operand_valid_i) && !full_i;
  assign last = (rem_q <= vl_t'(move_cnt));

  assign push_id_o   = issue_id_i;
  assign push_addr_o = {issue_vd_i, word_q};

  //////////////////////////////////////////////////
  // Lane copy and FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    word_d          = word_q;
    rem_d           = rem_q;
    acc_be_d        = acc_be_q;
    issue_done_o    = 1'b0;
    operand_ready_o = '0;
    push_o          = 1'b0;
    push_last_o     = 1'b0;

    // Output lanes in the moving window take their source lane, others keep the word
    push_wdata_o = acc_wdata_q;
    push_be_o    = acc_be_q;
    for (int o = 0; o < NrLanes; o++) begin
      if (o >= out_pnt_q && o < out_pnt_q + move_cnt) begin
        push_wdata_o[o] = operand_i[LaneIdxWidth'(o + in_pnt_q - out_pnt_q)];
        push_be_o[o]    = '1;
      end
    end

    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          state_d  = RUN;
          acc_be_d = '0;
          if (issue_op_i == SLIDE_UP) begin
            // Read from element 0, write from the stride onwards
            in_pnt_d  = '0;
            out_pnt_d = elem_pnt_t'(issue_stride_i[LaneIdxWidth-1:0]);
            word_d    = issue_stride_i[LaneIdxWidth +: WordIdxWidth];
            rem_d     = issue_vl_i - issue_stride_i;
          end else begin
            // Read from the stride onwards, write from element 0
            in_pnt_d  = elem_pnt_t'(issue_stride_i[LaneIdxWidth-1:0]);
            out_pnt_d = '0;
            word_d    = '0;
            rem_d     = issue_vl_i;
          end
        end
      end
      RUN: begin
        if (fire) begin
          in_pnt_d  = in_pnt_q + move_cnt;
          out_pnt_d = out_pnt_q + move_cnt;
          rem_d     = rem_q - vl_t'(move_cnt);
          acc_be_d  = push_be_o;
          // Input word used up, take the next one
          if (in_pnt_d == NrLanes || last) begin
            in_pnt_d        = '0;
            operand_ready_o = '1;
          end
          // Output word complete, hand it to staging
          if (out_pnt_d == NrLanes || last) begin
            out_pnt_d   = '0;
            word_d      = word_q + 1'b1;
            acc_be_d    = '0;
            push_o      = 1'b1;
            push_last_o = last;
          end
          if (last) begin
            state_d      = IDLE;
            issue_done_o = 1'b1;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      word_q    <= '0;
      rem_q     <= '0;
      acc_be_q  <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      word_q    <= word_d;
      rem_q     <= rem_d;
      acc_be_q  <= acc_be_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      acc_wdata_q <= push_wdata_o;
    end
  end

endmodule

// File: rtl/slide_result_queue.sv
/*
 * Result words wait here until every written lane is granted
 * Lanes without strobes never request, and a word with no strobes retires at once
 */
module slide_result_queue (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Push side from the engine
  input  logic                                      push_i,
  input  slide_pkg::vid_t                           push_id_i,
  input  slide_pkg::vaddr_t                         push_addr_i,
  input  slide_pkg::elem_t [slide_pkg::NrLanes-1:0] push_wdata_i,
  input  slide_pkg::strb_t [slide_pkg::NrLanes-1:0] push_be_i,
  input  logic                                      push_last_i,
  output logic                                      full_o,
  // Lane write ports
  output logic [slide_pkg::NrLanes-1:0]             result_req_o,
  output slide_pkg::vid_t                           result_id_o,
  output slide_pkg::vaddr_t                         result_addr_o,
  output slide_pkg::elem_t [slide_pkg::NrLanes-1:0] result_wdata_o,
  output slide_pkg::strb_t [slide_pkg::NrLanes-1:0] result_be_o,
  input  logic [slide_pkg::NrLanes-1:0]             result_gnt_i,
  output logic                                      drain_last_o
);
  import slide_pkg::*;

  // Entry payload
  vid_t                  id_q    [ResultQueueDepth];
  vaddr_t                addr_q  [ResultQueueDepth];
  logic                  last_q  [ResultQueueDepth];
  elem_t [NrLanes-1:0]   wdata_q [ResultQueueDepth];
  strb_t [NrLanes-1:0]   be_q    [ResultQueueDepth];
  // Lanes of each entry still waiting for a grant
  logic  [NrLanes-1:0]   valid_q [ResultQueueDepth];

  logic [ResultPntWidth-1:0] wr_pnt_q, rd_pnt_q;
  logic [ResultPntWidth:0]   cnt_q;
  logic [NrLanes-1:0]        push_lanes;
  logic                      retire;

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      push_lanes[l] = |push_be_i[l];
    end
  end

  assign full_o = (cnt_q == ResultQueueDepth);

  // Head entry drives the lanes
  assign result_req_o   = valid_q[rd_pnt_q];
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];

  // Head retires once its last pending lane is granted
  assign retire       = (cnt_q != '0) && ((valid_q[rd_pnt_q] & ~result_gnt_i) == '0);
  assign drain_last_o = retire && last_q[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_pnt_q]    <= push_id_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      last_q[wr_pnt_q]  <= push_last_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < ResultQueueDepth; i++) begin
        valid_q[i] <= '0;
      end
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      for (int i = 0; i < ResultQueueDepth; i++) begin
        // Push never targets the head while it is still pending
        if (push_i && wr_pnt_q == ResultPntWidth'(i)) begin
          valid_q[i] <= push_lanes;
        end else if (rd_pnt_q == ResultPntWidth'(i)) begin
          valid_q[i] <= valid_q[i] & ~result_gnt_i;
        end
      end
      if (push_i) begin
        wr_pnt_q <= (wr_pnt_q == ResultQueueDepth - 1) ? '0 : wr_pnt_q + 1'b1;
      end
      if (retire) begin
        rd_pnt_q <= (rd_pnt_q == ResultQueueDepth - 1) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + push_i - retire;
    end
  end

endmodule

// File: rtl/slide_unit.sv
/*
 * Slide-up and slide-down on 64-bit elements, no masking and no reductions
 * Requests need 1 <= vl <= VlenElems and stride < vl
 */
module slide_unit (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Request side
  input  logic                                      req_valid_i,
  output logic                                      req_ready_o,
  input  slide_pkg::slide_op_e                      req_op_i,
  input  slide_pkg::vid_t                           req_id_i,
  input  slide_pkg::vl_t                            req_vl_i,
  input  slide_pkg::vl_t                            req_stride_i,
  input  slide_pkg::vreg_t                          req_vd_i,
  // Operand side
  input  slide_pkg::elem_t [slide_pkg::NrLanes-1:0] operand_i,
  input  logic [slide_pkg::NrLanes-1:0]             operand_valid_i,
  output logic [slide_pkg::NrLanes-1:0]             operand_ready_o,
  // Result side
  output logic [slide_pkg::NrLanes-1:0]             result_req_o,
  output slide_pkg::vid_t                           result_id_o,
  output slide_pkg::vaddr_t                         result_addr_o,
  output slide_pkg::elem_t [slide_pkg::NrLanes-1:0] result_wdata_o,
  output slide_pkg::strb_t [slide_pkg::NrLanes-1:0] result_be_o,
  input  logic [slide_pkg::NrLanes-1:0]             result_gnt_i,
  // Done side
  output logic [slide_pkg::NrVInsn-1:0]             done_o
);
  import slide_pkg::*;

  // Issue entry
  logic      issue_valid, issue_done;
  slide_op_e issue_op;
  vid_t      issue_id;
  vl_t       issue_vl, issue_stride;
  vreg_t     issue_vd;

  // Engine to staging
  logic                push, push_last, full, drain_last;
  vid_t                push_id;
  vaddr_t              push_addr;
  elem_t [NrLanes-1:0] push_wdata;
  strb_t [NrLanes-1:0] push_be;

  slide_insn_queue insn_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .req_id_i       (req_id_i),
    .req_vl_i       (req_vl_i),
    .req_stride_i   (req_stride_i),
    .req_vd_i       (req_vd_i),
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op),
    .issue_id_o     (issue_id),
    .issue_vl_o     (issue_vl),
    .issue_stride_o (issue_stride),
    .issue_vd_o     (issue_vd),
    .issue_done_i   (issue_done),
    .drain_last_i   (drain_last),
    .done_o         (done_o)
  );

  slide_engine engine_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_valid_i   (issue_valid),
    .issue_op_i      (issue_op),
    .issue_id_i      (issue_id),
    .issue_vl_i      (issue_vl),
    .issue_stride_i  (issue_stride),
    .issue_vd_i      (issue_vd),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .full_i          (full),
    .push_o          (push),
    .push_id_o       (push_id),
    .push_addr_o     (push_addr),
    .push_wdata_o    (push_wdata),
    .push_be_o       (push_be),
    .push_last_o     (push_last)
  );

  slide_result_queue result_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_id_i      (push_id),
    .push_addr_i    (push_addr),
    .push_wdata_i   (push_wdata),
    .push_be_i      (push_be),
    .push_last_i    (push_last),
    .full_o         (full),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .drain_last_o   (drain_last)
  );

endmodule

// File: bench/slide_unit_assert.sv
/*
 * Protocol properties of the slide unit, bound into its top level
 * Accepted requests are seen through the instruction queue accept pointer
 */
module slide_unit_assert (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic                               req_valid_i,
  input logic                               req_ready_o,
  input logic [slide_pkg::InsnPntWidth-1:0] accept_pnt_i,
  input logic [slide_pkg::NrLanes-1:0]      result_req_o,
  input logic [slide_pkg::NrLanes-1:0]      result_gnt_i,
  input slide_pkg::vid_t                    result_id_o,
  input logic [slide_pkg::NrVInsn-1:0]      done_o
);
  import slide_pkg::*;

  // Count of failed properties
  int unsigned        fail_cnt = 0;
  // Lanes requesting without a grant this cycle
  logic [NrLanes-1:0] pending;

  assign pending = result_req_o & ~result_gnt_i;

  // A lane request stays up until its grant
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending != '0 |=> (result_req_o & $past(pending)) == $past(pending))
    else begin
      $error("lane request dropped before its grant");
      fail_cnt = fail_cnt + 1;
    end

  // A done pulse is one-hot and names the id of the word that retired a cycle before
  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o != '0 |-> done_o == (NrVInsn'(1) << $past(result_id_o)))
    else begin
      $error("done pulse does not name the id of the retired word");
      fail_cnt = fail_cnt + 1;
    end

  // No accept while the queue is full
  no_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_o |=> $stable(accept_pnt_i))
    else begin
      $error("request accepted while ready was low");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind slide_unit slide_unit_assert assert_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_valid_i  (req_valid_i),
  .req_ready_o  (req_ready_o),
  .accept_pnt_i (insn_queue_inst.accept_pnt_q),
  .result_req_o (result_req_o),
  .result_gnt_i (result_gnt_i),
  .result_id_o  (result_id_o),
  .done_o       (done_o)
);

// File: bench/tb_slide_unit.sv
/*
 * Slides through the unit with a source model, random operand gaps and grant delays
 * Each slide writes its own register vd = serial mod 32, so in-flight slides never share one
 */
module tb_slide_unit;
  import slide_pkg::*;

  localparam int Lanes         = int'(NrLanes);
  localparam int Elems         = int'(VlenElems);
  localparam int NrVRegs       = 2 ** $bits(vreg_t);
  localparam int NumDirected   = 5;
  localparam int NumRandom     = 30;
  localparam int NumInsn       = NumDirected + NumRandom;
  localparam int TimeoutCycles = 200 * NumInsn + 100;

  logic                clk_i;
  logic                rst_ni;
  logic                req_valid_i, req_ready_o;
  slide_op_e           req_op_i;
  vid_t                req_id_i;
  vl_t                 req_vl_i, req_stride_i;
  vreg_t               req_vd_i;
  elem_t [NrLanes-1:0] operand_i;
  logic  [NrLanes-1:0] operand_valid_i, operand_ready_o;
  logic  [NrLanes-1:0] result_req_o, result_gnt_i;
  vid_t                result_id_o;
  vaddr_t              result_addr_o;
  elem_t [NrLanes-1:0] result_wdata_o;
  strb_t [NrLanes-1:0] result_be_o;
  logic  [NrVInsn-1:0] done_o;

  // Accepted slides by serial number
  slide_op_e ins_op     [NumInsn];
  int        ins_vl     [NumInsn];
  int        ins_stride [NumInsn];
  string     ins_name   [NumInsn];
  int        n_accepted, feed_idx, feed_word, done_idx, cycles;
  // Random slides, drawn before reset ends
  slide_op_e rnd_op     [NumRandom];
  int        rnd_vl     [NumRandom];
  int        rnd_stride [NumRandom];
  // Destination model, index = address * lanes + lane
  elem_t     dst_val    [NrVRegs * Elems];
  strb_t     dst_be     [NrVRegs * Elems];
  logic [31:0] lfsr_q;
  logic        rand_en;

  slide_unit slide_unit_inst (.*);

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Random bits and reference model
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v      = {v[30:0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Source element e of slide k, tagged with both so stale data shows up
  function automatic elem_t src_elem(input int k, input int e);
    logic [47:0] mix;
    mix = 48'(k * 64 + e + 1) * 48'h9e37_79b9_7f4b;
    return {8'(k), 8'(e), mix};
  endfunction

  // Bit 64 flags a written destination element
  function automatic logic [64:0] ref_elem(input int k, input int i);
    if (ins_op[k] == SLIDE_UP) begin
      if (i >= ins_stride[k] && i < ins_vl[k]) begin
        return {1'b1, src_elem(k, i - ins_stride[k])};
      end
    end else if (i < ins_vl[k]) begin
      return {1'b1, src_elem(k, i + ins_stride[k])};
    end
    return '0;
  endfunction

  // Operand stream of a slide: first source word and number of words
  function automatic int first_word(input int k);
    return (ins_op[k] == SLIDE_UP) ? 0 : ins_stride[k] / Lanes;
  endfunction

  function automatic int word_count(input int k);
    if (ins_op[k] == SLIDE_UP) begin
      return (ins_vl[k] - ins_stride[k] + Lanes - 1) / Lanes;
    end
    return (ins_stride[k] + ins_vl[k] - 1) / Lanes - ins_stride[k] / Lanes + 1;
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_on_failure($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // Whole destination register of slide k against the reference
  task automatic check_insn(input int k);
    logic [64:0] r;
    int          base;
    base = (k % NrVRegs) * Elems;
    for (int i = 0; i < Elems; i++) begin
      r = ref_elem(k, i);
      check_value($sformatf("%s elem %0d strobes", ins_name[k], i),
                  r[64] ? 64'hff : 64'h0, 64'(dst_be[base+i]));
      if (r[64]) begin
        check_value($sformatf("%s elem %0d data", ins_name[k], i), r[63:0], dst_val[base+i]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Lane models on the falling edge
  //////////////////////////////////////////////////

  // Drive first and then record the lane writes that the coming rising edge grants
  always @(negedge clk_i) begin : lane_models
    logic [31:0] r;
    int          idx;
    if (rst_ni) begin
      if (slide_unit_inst.assert_inst.fail_cnt != 0) begin
        stop_on_failure("A protocol assertion on the slide unit failed");
      end
      // Done pulse belongs to the oldest uncommitted slide
      if (done_o != '0) begin
        check_value($sformatf("%s done", ins_name[done_idx]),
                    64'(1) << (done_idx % NrVInsn), 64'(done_o));
        check_insn(done_idx);
        done_idx++;
      end
      // Same bit count every cycle keeps the sequence fixed
      take_bits(2, r);
      if (feed_idx < n_accepted && (!rand_en || r[1:0] != 2'b00)) begin
        operand_valid_i = '1;
        for (int l = 0; l < Lanes; l++) begin
          operand_i[l] = src_elem(feed_idx, (first_word(feed_idx) + feed_word) * Lanes + l);
        end
      end else begin
        operand_valid_i = '0;
      end
      take_bits(Lanes, r);
      result_gnt_i = result_req_o & (rand_en ? r[Lanes-1:0] : '1);
      // Lane writes granted at the coming rising edge
      for (int l = 0; l < Lanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          check_value($sformatf("%s result id", ins_name[done_idx]),
                      done_idx % NrVInsn, 64'(result_id_o));
          check_value($sformatf("%s result register", ins_name[done_idx]),
                      done_idx % NrVRegs, 64'(result_addr_o >> WordIdxWidth));
          idx          = int'(result_addr_o) * Lanes + l;
          dst_val[idx] = result_wdata_o[l];
          dst_be[idx]  = result_be_o[l];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    // Operand word taken at this rising edge
    if (rst_ni && &operand_valid_i && &operand_ready_o) begin
      feed_word++;
      if (feed_word == word_count(feed_idx)) begin
        feed_idx++;
        feed_word = 0;
      end
    end
    if (cycles >= TimeoutCycles) begin
      stop_on_failure($sformatf("Timeout after %0d cycles with %0d of %0d slides done",
                                cycles, done_idx, n_accepted));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Starts on a falling edge and returns on the one after the accept
  task automatic send_insn(input string name, input slide_op_e op, input int vl,
                           input int stride);
    int k;
    k             = n_accepted;
    ins_op[k]     = op;
    ins_vl[k]     = vl;
    ins_stride[k] = stride;
    ins_name[k]   = name;
    for (int i = 0; i < Elems; i++) begin
      dst_val[(k % NrVRegs) * Elems + i] = '0;
      dst_be[(k % NrVRegs) * Elems + i]  = '0;
    end
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_id_i     = vid_t'(k % NrVInsn);
    req_vl_i     = vl_t'(vl);
    req_stride_i = vl_t'(stride);
    req_vd_i     = vreg_t'(k % NrVRegs);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    n_accepted++;
  endtask

  task automatic wait_idle();
    while (done_idx < n_accepted) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [31:0] r;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = SLIDE_UP;
    req_id_i        = '0;
    req_vl_i        = '0;
    req_stride_i    = '0;
    req_vd_i        = '0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = '0;
    lfsr_q          = 32'h50c1983d;
    rand_en         = 1'b0;
    n_accepted      = 0;
    feed_idx        = 0;
    feed_word       = 0;
    done_idx        = 0;
    cycles          = 0;
    // Legal random slides, 1 <= vl <= 32 and stride < vl
    for (int j = 0; j < NumRandom; j++) begin
      take_bits(1, r);
      rnd_op[j] = r[0] ? SLIDE_DOWN : SLIDE_UP;
      take_bits(5, r);
      rnd_vl[j] = int'(r[4:0]) + 1;
      take_bits(5, r);
      rnd_stride[j] = int'(r[4:0]) % rnd_vl[j];
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    send_insn("up_stride0", SLIDE_UP, 13, 0);
    wait_idle();
    send_insn("up_unaligned", SLIDE_UP, 27, 6);
    wait_idle();
    send_insn("down_partial", SLIDE_DOWN, 14, 5);
    wait_idle();
    // Two in flight fill the instruction queue
    send_insn("pair_first", SLIDE_UP, 20, 3);
    send_insn("pair_second", SLIDE_DOWN, 9, 2);
    check_value("pair_ready", 64'h0, 64'(req_ready_o));
    wait_idle();

    rand_en = 1'b1;
    for (int j = 0; j < NumRandom; j++) begin
      send_insn($sformatf("random_%0d", j), rnd_op[j], rnd_vl[j], rnd_stride[j]);
    end
    wait_idle();

    if (slide_unit_inst.assert_inst.fail_cnt != 0) begin
      stop_on_failure("A protocol assertion on the slide unit failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: compile.f
rtl/slide_pkg.sv
rtl/slide_insn_queue.sv
rtl/slide_engine.sv
rtl/slide_result_queue.sv
rtl/slide_unit.sv
bench/slide_unit_assert.sv
bench/tb_slide_unit.sv
